// File: common/nbody_pkg.sv
`default_nettype none

package nbody_pkg;

  // ========================================
  // Widths and limits
  // ========================================
  localparam int MAX_BODIES = 512;

  typedef logic [31:0] bus_word_t;
  typedef logic [63:0] word_t;
  typedef logic [8:0]  body_idx_t;
  typedef logic [6:0]  reg_code_t;

  // ========================================
  // Register codes, address bits 15 to 9
  // ========================================
  localparam reg_code_t CODE_GO       = 7'h40;
  localparam reg_code_t CODE_READ     = 7'h41;
  localparam reg_code_t CODE_N_BODIES = 7'h42;
  localparam reg_code_t CODE_GAP      = 7'h43;
  localparam reg_code_t CODE_X_LO     = 7'h44;
  localparam reg_code_t CODE_X_HI     = 7'h45;
  localparam reg_code_t CODE_Y_LO     = 7'h46;
  localparam reg_code_t CODE_Y_HI     = 7'h47;
  localparam reg_code_t CODE_VX_LO    = 7'h4a;
  localparam reg_code_t CODE_VX_HI    = 7'h4b;
  localparam reg_code_t CODE_VY_LO    = 7'h4c;
  localparam reg_code_t CODE_VY_HI    = 7'h4d;
  localparam reg_code_t CODE_DONE     = 7'h50;
  localparam reg_code_t CODE_RD_X_LO  = 7'h51;
  localparam reg_code_t CODE_RD_X_HI  = 7'h52;
  localparam reg_code_t CODE_RD_Y_LO  = 7'h53;
  localparam reg_code_t CODE_RD_Y_HI  = 7'h54;

  typedef enum logic [1:0] {FIELD_X, FIELD_Y, FIELD_VX, FIELD_VY} field_e;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_DRAIN} seq_state_e;

  typedef struct packed {
    logic        chipselect;
    logic        read;
    logic        write;
    logic [15:0] addr;
    bus_word_t   writedata;
  } bus_req_t;

  typedef struct packed {
    logic      valid;
    field_e    field;
    body_idx_t index;
    word_t     data;
  } mem_wr_t;

  typedef struct packed {
    logic      valid;
    body_idx_t index;
    word_t     x;
    word_t     y;
  } upd_item_t;

endpackage

`default_nettype wire

// File: body_mem/body_ram.sv
`timescale 1ns/100ps
`default_nettype none

module body_ram #(
  parameter int DEPTH = 512
) (
  input  wire logic                 clk,
  input  wire logic                 we_i,
  input  wire nbody_pkg::body_idx_t waddr_i,
  input  wire nbody_pkg::word_t     wdata_i,
  input  wire nbody_pkg::body_idx_t raddr_i,
  output nbody_pkg::word_t          rdata_o
);

  nbody_pkg::word_t mem [DEPTH];

  // Same-edge read returns the word from before the write
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

// File: body_mem/body_store.sv
`timescale 1ns/100ps
`default_nettype none

module body_store #(
  parameter int DEPTH = 512
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  busy_i,
  input  wire nbody_pkg::mem_wr_t    mem_wr_i,
  input  wire nbody_pkg::body_idx_t  rd_idx_i,
  input  wire logic                  upd_rd_valid_i,
  input  wire nbody_pkg::body_idx_t  upd_rd_idx_i,
  input  wire nbody_pkg::upd_item_t  wb_i,
  output nbody_pkg::upd_item_t       upd_o,
  output nbody_pkg::word_t           rd_x_o,
  output nbody_pkg::word_t           rd_y_o
);

  nbody_pkg::body_idx_t raddr;
  logic                 sw_we;
  logic                 x_we;
  logic                 y_we;
  nbody_pkg::body_idx_t pos_waddr;
  nbody_pkg::word_t     vx_rd;
  nbody_pkg::word_t     vy_rd;
  logic                 upd_valid_q;
  nbody_pkg::body_idx_t upd_idx_q;

  assign raddr = busy_i ? upd_rd_idx_i : rd_idx_i;
  assign sw_we = mem_wr_i.valid & ~busy_i;

  // Write-backs win the position ports
  assign x_we      = wb_i.valid | (sw_we & (mem_wr_i.field == nbody_pkg::FIELD_X));
  assign y_we      = wb_i.valid | (sw_we & (mem_wr_i.field == nbody_pkg::FIELD_Y));
  assign pos_waddr = wb_i.valid ? wb_i.index : mem_wr_i.index;

  body_ram #(.DEPTH(DEPTH)) u_x_ram (
    .clk     (clk),
    .we_i    (x_we),
    .waddr_i (pos_waddr),
    .wdata_i (wb_i.valid ? wb_i.x : mem_wr_i.data),
    .raddr_i (raddr),
    .rdata_o (rd_x_o)
  );

  body_ram #(.DEPTH(DEPTH)) u_y_ram (
    .clk     (clk),
    .we_i    (y_we),
    .waddr_i (pos_waddr),
    .wdata_i (wb_i.valid ? wb_i.y : mem_wr_i.data),
    .raddr_i (raddr),
    .rdata_o (rd_y_o)
  );

  body_ram #(.DEPTH(DEPTH)) u_vx_ram (
    .clk     (clk),
    .we_i    (sw_we & (mem_wr_i.field == nbody_pkg::FIELD_VX)),
    .waddr_i (mem_wr_i.index),
    .wdata_i (mem_wr_i.data),
    .raddr_i (raddr),
    .rdata_o (vx_rd)
  );

  body_ram #(.DEPTH(DEPTH)) u_vy_ram (
    .clk     (clk),
    .we_i    (sw_we & (mem_wr_i.field == nbody_pkg::FIELD_VY)),
    .waddr_i (mem_wr_i.index),
    .wdata_i (mem_wr_i.data),
    .raddr_i (raddr),
    .rdata_o (vy_rd)
  );

  // Valid and index follow the RAM read latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      upd_valid_q <= 1'b0;
    end else begin
      upd_valid_q <= upd_rd_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    upd_idx_q <= upd_rd_idx_i;
  end

  // Two's-complement sums wrap at 64 bits
  assign upd_o.valid = upd_valid_q;
  assign upd_o.index = upd_idx_q;
  assign upd_o.x     = rd_x_o + vx_rd;
  assign upd_o.y     = rd_y_o + vy_rd;

endmodule

`default_nettype wire

// File: source/pos_update.sv
`timescale 1ns/100ps
`default_nettype none

module pos_update #(
  parameter int ADD_LAT = 9
) (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire nbody_pkg::upd_item_t item_i,
  output nbody_pkg::upd_item_t      item_o
);

  logic [ADD_LAT-1:0]   vld_q;
  nbody_pkg::upd_item_t pay_q [ADD_LAT];

  // Valid bits are the only reset state in the pipe
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[ADD_LAT-2:0], item_i.valid};
    end
  end

  always_ff @(posedge clk) begin
    pay_q[0] <= item_i;
    for (int i = 1; i < ADD_LAT; i++) begin
      pay_q[i] <= pay_q[i-1];
    end
  end

  always_comb begin
    item_o       = pay_q[ADD_LAT-1];
    item_o.valid = vld_q[ADD_LAT-1];
  end

endmodule

`default_nettype wire

// File: source/step_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module step_sequencer (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 go_i,
  input  wire logic                 read_flag_i,
  input  wire nbody_pkg::body_idx_t n_bodies_i,
  input  wire nbody_pkg::bus_word_t gap_i,
  input  wire logic                 wb_valid_i,
  output logic                      busy_o,
  output logic                      upd_rd_valid_o,
  output nbody_pkg::body_idx_t      upd_rd_idx_o,
  output logic                      done_o
);

  nbody_pkg::seq_state_e state_q;
  nbody_pkg::body_idx_t  rd_cnt_q;
  nbody_pkg::body_idx_t  wb_cnt_q;
  nbody_pkg::bus_word_t  step_cnt_q;

  assign busy_o         = (state_q != nbody_pkg::SEQ_IDLE);
  assign upd_rd_valid_o = (state_q == nbody_pkg::SEQ_ISSUE);
  assign upd_rd_idx_o   = rd_cnt_q;

  // ========================================
  // Run FSM
  // ========================================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= nbody_pkg::SEQ_IDLE;
      rd_cnt_q   <= '0;
      wb_cnt_q   <= '0;
      step_cnt_q <= '0;
      done_o     <= 1'b0;
    end else begin
      // Count write-backs of the current step
      if (busy_o && wb_valid_i) begin
        wb_cnt_q <= wb_cnt_q + 1'b1;
      end

      if (!go_i) begin
        // Abort, in-flight items still land in the RAMs
        state_q <= nbody_pkg::SEQ_IDLE;
      end else begin
        case (state_q)
          nbody_pkg::SEQ_IDLE: begin
            if (done_o && read_flag_i) begin
              done_o <= 1'b0;
            end else if (!read_flag_i && !done_o) begin
              state_q    <= nbody_pkg::SEQ_ISSUE;
              step_cnt_q <= '0;
              rd_cnt_q   <= '0;
              wb_cnt_q   <= '0;
            end
          end
          nbody_pkg::SEQ_ISSUE: begin
            rd_cnt_q <= rd_cnt_q + 1'b1;
            if (rd_cnt_q == n_bodies_i - 1'b1) begin
              state_q <= nbody_pkg::SEQ_DRAIN;
            end
          end
          nbody_pkg::SEQ_DRAIN: begin
            if (wb_cnt_q == n_bodies_i) begin
              if (step_cnt_q == gap_i - 1'b1) begin
                done_o  <= 1'b1;
                state_q <= nbody_pkg::SEQ_IDLE;
              end else begin
                // Next step reads the positions just written
                step_cnt_q <= step_cnt_q + 1'b1;
                rd_cnt_q   <= '0;
                wb_cnt_q   <= '0;
                state_q    <= nbody_pkg::SEQ_ISSUE;
              end
            end
          end
          default: state_q <= nbody_pkg::SEQ_IDLE;
        endcase
      end
    end
  end

  a_done_idle: assert property (@(posedge clk) disable iff (rst)
    done_o |-> (state_q == nbody_pkg::SEQ_IDLE));

  a_rd_in_range: assert property (@(posedge clk) disable iff (rst)
    upd_rd_valid_o |-> (upd_rd_idx_o < n_bodies_i));

endmodule

`default_nettype wire

// File: source/nbody_regs.sv
`timescale 1ns/100ps
`default_nettype none

module nbody_regs (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire nbody_pkg::bus_req_t  bus_req_i,
  input  wire logic                 done_i,
  input  wire nbody_pkg::word_t     rd_x_i,
  input  wire nbody_pkg::word_t     rd_y_i,
  output nbody_pkg::mem_wr_t        mem_wr_o,
  output nbody_pkg::body_idx_t      rd_idx_o,
  output logic                      go_o,
  output logic                      read_flag_o,
  output nbody_pkg::body_idx_t      n_bodies_o,
  output nbody_pkg::bus_word_t      gap_o,
  output nbody_pkg::bus_word_t      readdata_o
);

  nbody_pkg::reg_code_t code;
  nbody_pkg::bus_word_t lo_word_q;
  nbody_pkg::reg_code_t rd_code_q;
  logic                 rd_pending_q;
  logic                 wr_stb;
  logic                 rd_stb;

  assign code     = bus_req_i.addr[15:9];
  assign rd_idx_o = bus_req_i.addr[8:0];
  assign wr_stb   = bus_req_i.chipselect & bus_req_i.write;
  assign rd_stb   = bus_req_i.chipselect & bus_req_i.read;

  // ========================================
  // Control registers
  // ========================================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      go_o         <= 1'b0;
      read_flag_o  <= 1'b0;
      n_bodies_o   <= '0;
      gap_o        <= '0;
      rd_pending_q <= 1'b0;
    end else begin
      rd_pending_q <= rd_stb;
      if (wr_stb) begin
        case (code)
          nbody_pkg::CODE_GO:       go_o        <= bus_req_i.writedata[0];
          nbody_pkg::CODE_READ:     read_flag_o <= bus_req_i.writedata[0];
          nbody_pkg::CODE_N_BODIES: n_bodies_o  <= nbody_pkg::body_idx_t'(bus_req_i.writedata);
          nbody_pkg::CODE_GAP:      gap_o       <= bus_req_i.writedata;
          default: ;
        endcase
      end
    end
  end

  // Lower halves wait here for their upper half
  always_ff @(posedge clk) begin
    if (wr_stb && (code == nbody_pkg::CODE_X_LO || code == nbody_pkg::CODE_Y_LO ||
                   code == nbody_pkg::CODE_VX_LO || code == nbody_pkg::CODE_VY_LO)) begin
      lo_word_q <= bus_req_i.writedata;
    end
    if (rd_stb) begin
      rd_code_q <= code;
    end
  end

  // Upper half completes the 64-bit word
  always_comb begin
    mem_wr_o       = '0;
    mem_wr_o.index = bus_req_i.addr[8:0];
    mem_wr_o.data  = {bus_req_i.writedata, lo_word_q};
    case (code)
      nbody_pkg::CODE_X_HI: begin
        mem_wr_o.valid = wr_stb;
        mem_wr_o.field = nbody_pkg::FIELD_X;
      end
      nbody_pkg::CODE_Y_HI: begin
        mem_wr_o.valid = wr_stb;
        mem_wr_o.field = nbody_pkg::FIELD_Y;
      end
      nbody_pkg::CODE_VX_HI: begin
        mem_wr_o.valid = wr_stb;
        mem_wr_o.field = nbody_pkg::FIELD_VX;
      end
      nbody_pkg::CODE_VY_HI: begin
        mem_wr_o.valid = wr_stb;
        mem_wr_o.field = nbody_pkg::FIELD_VY;
      end
      default: ;
    endcase
  end

  // Read data lines up with the RAM output one cycle after the strobe
  always_comb begin
    readdata_o = '0;
    if (rd_pending_q) begin
      case (rd_code_q)
        nbody_pkg::CODE_DONE:    readdata_o = {31'b0, done_i};
        nbody_pkg::CODE_RD_X_LO: readdata_o = rd_x_i[31:0];
        nbody_pkg::CODE_RD_X_HI: readdata_o = rd_x_i[63:32];
        nbody_pkg::CODE_RD_Y_LO: readdata_o = rd_y_i[31:0];
        nbody_pkg::CODE_RD_Y_HI: readdata_o = rd_y_i[63:32];
        default:                 readdata_o = '1;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/nbody_top.sv
`timescale 1ns/100ps
`default_nettype none

module nbody_top #(
  parameter int DEPTH   = nbody_pkg::MAX_BODIES,
  parameter int ADD_LAT = 9
) (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire nbody_pkg::bus_req_t bus_req_i,
  output nbody_pkg::bus_word_t     readdata_o
);

  nbody_pkg::mem_wr_t   mem_wr;
  nbody_pkg::body_idx_t rd_idx;
  nbody_pkg::body_idx_t n_bodies;
  nbody_pkg::bus_word_t gap;
  nbody_pkg::word_t     rd_x;
  nbody_pkg::word_t     rd_y;
  nbody_pkg::upd_item_t upd_item;
  nbody_pkg::upd_item_t wb_item;
  nbody_pkg::body_idx_t upd_rd_idx;
  logic                 go;
  logic                 read_flag;
  logic                 done;
  logic                 busy;
  logic                 upd_rd_valid;

  nbody_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .bus_req_i   (bus_req_i),
    .done_i      (done),
    .rd_x_i      (rd_x),
    .rd_y_i      (rd_y),
    .mem_wr_o    (mem_wr),
    .rd_idx_o    (rd_idx),
    .go_o        (go),
    .read_flag_o (read_flag),
    .n_bodies_o  (n_bodies),
    .gap_o       (gap),
    .readdata_o  (readdata_o)
  );

  body_store #(.DEPTH(DEPTH)) u_store (
    .clk            (clk),
    .rst            (rst),
    .busy_i         (busy),
    .mem_wr_i       (mem_wr),
    .rd_idx_i       (rd_idx),
    .upd_rd_valid_i (upd_rd_valid),
    .upd_rd_idx_i   (upd_rd_idx),
    .wb_i           (wb_item),
    .upd_o          (upd_item),
    .rd_x_o         (rd_x),
    .rd_y_o         (rd_y)
  );

  pos_update #(.ADD_LAT(ADD_LAT)) u_update (
    .clk    (clk),
    .rst    (rst),
    .item_i (upd_item),
    .item_o (wb_item)
  );

  step_sequencer u_seq (
    .clk            (clk),
    .rst            (rst),
    .go_i           (go),
    .read_flag_i    (read_flag),
    .n_bodies_i     (n_bodies),
    .gap_i          (gap),
    .wb_valid_i     (wb_item.valid),
    .busy_o         (busy),
    .upd_rd_valid_o (upd_rd_valid),
    .upd_rd_idx_o   (upd_rd_idx),
    .done_o         (done)
  );

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int HALF_NS = 20
) (
  output logic clk_o
);

  // 40 ns period with the default half period
  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: verif/nbody_tb.sv
`timescale 1ns/100ps
`default_nettype none

module nbody_tb;

  localparam int    ADD_LAT     = 9;
  localparam int    TIMEOUT_CYC = 20000;
  localparam int    DATA_WORDS  = 37;
  localparam string DATA_FILE   = "verif/nbody_testdata.txt";

  logic                 clk;
  logic                 rst;
  nbody_pkg::bus_req_t  bus_req;
  nbody_pkg::bus_word_t readdata;

  nbody_pkg::word_t     tdata [DATA_WORDS];
  int                   errors;
  int                   checks;
  bit                   timed_out;
  nbody_pkg::bus_word_t lcg_state;

  tb_clock #(.HALF_NS(20)) u_clock (.clk_o(clk));

  nbody_top #(.ADD_LAT(ADD_LAT)) u_dut (
    .clk        (clk),
    .rst        (rst),
    .bus_req_i  (bus_req),
    .readdata_o (readdata)
  );

  // ========================================
  // Compare tasks
  // ========================================
  task automatic check_word(input string name, input nbody_pkg::word_t exp,
                            input nbody_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bus(input string name, input nbody_pkg::bus_word_t exp,
                           input nbody_pkg::bus_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic nbody_pkg::bus_word_t lcg_step(input nbody_pkg::bus_word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic nbody_pkg::word_t next_word();
    nbody_pkg::bus_word_t hi;
    lcg_state = lcg_step(lcg_state);
    hi = lcg_state;
    lcg_state = lcg_step(lcg_state);
    return {hi, lcg_state};
  endfunction

  // ========================================
  // Bus access
  // ========================================
  task automatic bus_write(input nbody_pkg::reg_code_t code, input nbody_pkg::body_idx_t idx,
                           input nbody_pkg::bus_word_t data);
    nbody_pkg::bus_req_t req;
    req = '0;
    req.chipselect = 1'b1;
    req.write      = 1'b1;
    req.addr       = {code, idx};
    req.writedata  = data;
    @(posedge clk);
    bus_req <= req;
    @(posedge clk);
    bus_req <= '0;
  endtask

  // Data is sampled mid-cycle in the cycle after the strobe
  task automatic bus_read(input nbody_pkg::reg_code_t code, input nbody_pkg::body_idx_t idx,
                          output nbody_pkg::bus_word_t data);
    nbody_pkg::bus_req_t req;
    req = '0;
    req.chipselect = 1'b1;
    req.read       = 1'b1;
    req.addr       = {code, idx};
    @(posedge clk);
    bus_req <= req;
    @(posedge clk);
    bus_req <= '0;
    @(negedge clk);
    data = readdata;
  endtask

  task automatic write_word(input nbody_pkg::reg_code_t lo_code,
                            input nbody_pkg::reg_code_t hi_code,
                            input nbody_pkg::body_idx_t idx, input nbody_pkg::word_t w);
    bus_write(lo_code, idx, w[31:0]);
    bus_write(hi_code, idx, w[63:32]);
  endtask

  task automatic read_word(input nbody_pkg::reg_code_t lo_code,
                           input nbody_pkg::reg_code_t hi_code,
                           input nbody_pkg::body_idx_t idx, output nbody_pkg::word_t w);
    nbody_pkg::bus_word_t lo;
    nbody_pkg::bus_word_t hi;
    bus_read(lo_code, idx, lo);
    bus_read(hi_code, idx, hi);
    w = {hi, lo};
  endtask

  task automatic load_body(input nbody_pkg::body_idx_t idx, input nbody_pkg::word_t x,
                           input nbody_pkg::word_t y, input nbody_pkg::word_t vx,
                           input nbody_pkg::word_t vy);
    write_word(nbody_pkg::CODE_X_LO, nbody_pkg::CODE_X_HI, idx, x);
    write_word(nbody_pkg::CODE_Y_LO, nbody_pkg::CODE_Y_HI, idx, y);
    write_word(nbody_pkg::CODE_VX_LO, nbody_pkg::CODE_VX_HI, idx, vx);
    write_word(nbody_pkg::CODE_VY_LO, nbody_pkg::CODE_VY_HI, idx, vy);
  endtask

  task automatic check_stored(input string name, input nbody_pkg::body_idx_t idx,
                              input nbody_pkg::word_t x, input nbody_pkg::word_t y);
    nbody_pkg::bus_word_t rd;
    bus_read(nbody_pkg::CODE_RD_X_LO, idx, rd);
    check_bus({name, " x lo"}, x[31:0], rd);
    bus_read(nbody_pkg::CODE_RD_X_HI, idx, rd);
    check_bus({name, " x hi"}, x[63:32], rd);
    bus_read(nbody_pkg::CODE_RD_Y_LO, idx, rd);
    check_bus({name, " y lo"}, y[31:0], rd);
    bus_read(nbody_pkg::CODE_RD_Y_HI, idx, rd);
    check_bus({name, " y hi"}, y[63:32], rd);
  endtask

  // Each poll of the done register takes two cycles
  task automatic wait_done(input string name);
    nbody_pkg::bus_word_t flag;
    int                   cycles;
    flag   = '0;
    cycles = 0;
    while (flag !== 32'd1 && cycles < TIMEOUT_CYC) begin
      bus_read(nbody_pkg::CODE_DONE, '0, flag);
      cycles += 2;
    end
    if (flag !== 32'd1) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: done did not rise within %0d cycles in %s", TIMEOUT_CYC, name);
    end
  endtask

  // Expected positions sit after x y vx vy in each body block
  task automatic check_positions(input int t, input int base, input int n, input int run);
    nbody_pkg::word_t act;
    int               bb;
    for (int b = 0; b < n; b++) begin
      bb = base + 2 + 8 * b + 2 + 2 * run;
      read_word(nbody_pkg::CODE_RD_X_LO, nbody_pkg::CODE_RD_X_HI, b, act);
      check_word($sformatf("test %0d run %0d body %0d x", t, run, b), tdata[bb], act);
      read_word(nbody_pkg::CODE_RD_Y_LO, nbody_pkg::CODE_RD_Y_HI, b, act);
      check_word($sformatf("test %0d run %0d body %0d y", t, run, b), tdata[bb + 1], act);
    end
  endtask

  // ========================================
  // Test sequences
  // ========================================
  task automatic run_file_test(input int t, input int base);
    int                   n;
    int                   bb;
    nbody_pkg::bus_word_t gap;
    nbody_pkg::bus_word_t rd;
    n   = int'(tdata[base]);
    gap = nbody_pkg::bus_word_t'(tdata[base + 1]);
    bus_write(nbody_pkg::CODE_N_BODIES, '0, nbody_pkg::bus_word_t'(n));
    bus_write(nbody_pkg::CODE_GAP, '0, gap);
    for (int b = 0; b < n; b++) begin
      bb = base + 2 + 8 * b;
      load_body(b, tdata[bb], tdata[bb + 1], tdata[bb + 2], tdata[bb + 3]);
    end
    for (int b = 0; b < n; b++) begin
      bb = base + 2 + 8 * b;
      check_stored($sformatf("test %0d load body %0d", t, b), b, tdata[bb], tdata[bb + 1]);
    end
    bus_write(nbody_pkg::CODE_GO, '0, 32'd1);
    wait_done($sformatf("test %0d run 1", t));
    if (timed_out) return;
    check_positions(t, base, n, 1);
    // Acknowledge and start a second run with go still high
    bus_write(nbody_pkg::CODE_READ, '0, 32'd1);
    bus_read(nbody_pkg::CODE_DONE, '0, rd);
    check_bus($sformatf("test %0d done after ack", t), 32'd0, rd);
    bus_write(nbody_pkg::CODE_READ, '0, 32'd0);
    wait_done($sformatf("test %0d run 2", t));
    if (timed_out) return;
    check_positions(t, base, n, 2);
    bus_write(nbody_pkg::CODE_READ, '0, 32'd1);
    bus_write(nbody_pkg::CODE_GO, '0, 32'd0);
    bus_write(nbody_pkg::CODE_READ, '0, 32'd0);
  endtask

  task automatic run_abort_test();
    nbody_pkg::bus_word_t rd;
    nbody_pkg::word_t     x [4];
    nbody_pkg::word_t     y [4];
    nbody_pkg::word_t     vx;
    nbody_pkg::word_t     vy;
    bus_write(nbody_pkg::CODE_N_BODIES, '0, 32'd16);
    bus_write(nbody_pkg::CODE_GAP, '0, 32'd2);
    bus_write(nbody_pkg::CODE_GO, '0, 32'd1);
    bus_read(7'h7f, '0, rd);
    check_bus("unknown code mid-run", '1, rd);
    // No strobe in the previous cycle, so the bus reads zero
    @(negedge clk);
    check_bus("idle read data", '0, readdata);
    bus_read(nbody_pkg::CODE_DONE, '0, rd);
    check_bus("done mid-run", 32'd0, rd);
    bus_write(nbody_pkg::CODE_GO, '0, 32'd0);
    // Items already in the adder pipe still land
    repeat (2 * (ADD_LAT + 1)) @(posedge clk);
    for (int b = 0; b < 4; b++) begin
      x[b] = next_word();
      y[b] = next_word();
      vx   = next_word();
      vy   = next_word();
      load_body(b, x[b], y[b], vx, vy);
    end
    for (int b = 0; b < 4; b++) begin
      check_stored($sformatf("abort reload body %0d", b), b, x[b], y[b]);
    end
    // Two steps of 16 bodies would have ended well before this read
    bus_read(nbody_pkg::CODE_DONE, '0, rd);
    check_bus("done after abort", 32'd0, rd);
  endtask

  initial begin
    int n_tests;
    int base;
    bus_req   = '0;
    rst       = 1'b1;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    lcg_state = 32'h45c2_e98d;
    $readmemh(DATA_FILE, tdata);
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    n_tests = int'(tdata[0]);
    if (n_tests == 0) begin
      errors++;
      $display("No tests found in %s", DATA_FILE);
    end
    base = 1;
    for (int t = 0; t < n_tests && !timed_out; t++) begin
      run_file_test(t, base);
      base = base + 2 + 8 * int'(tdata[base]);
    end
    if (!timed_out) begin
      run_abort_test();
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/nbody_testdata.txt
// Word 0 is the test count. Each test: body count, gap, then two lines per body
// Body lines: x y vx vy, then x and y after one run, x and y after two runs
0000000000000002
// Test 0: three bodies, gap 4, carries and wraps in both axes
0000000000000003 0000000000000004
00000000fffffff0 0000000000000200 0000000000000010 ffffffffffffffff
0000000100000030 00000000000001fc 0000000100000070 00000000000001f8
fffffffffffffff0 7ffffffffffffffe 0000000000000008 0000000000000001
0000000000000010 8000000000000002 0000000000000030 8000000000000006
123456789abcdef0 0000000100000000 0000000000000001 ffffffff00000000
123456789abcdef4 fffffffd00000000 123456789abcdef8 fffffff900000000
// Test 1: a single body, gap 5
0000000000000001 0000000000000005
8000000000000000 0000000000000000 ffffffffffffffff 0000000000000003
7ffffffffffffffb 000000000000000f 7ffffffffffffff6 000000000000001e

// File: sim.f
common/nbody_pkg.sv
body_mem/body_ram.sv
body_mem/body_store.sv
source/pos_update.sv
source/step_sequencer.sv
source/nbody_regs.sv
source/nbody_top.sv
verif/tb_clock.sv
verif/nbody_tb.sv
